// File: dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

    typedef enum logic [1:0] {
        L_IDLE,
        L_LOOKUP,
        // Waiting on the miss stage
        L_WAIT
    } lookup_state_e;

    typedef enum logic [1:0] {
        M_IDLE,
        M_WRITEBACK,
        M_READ,
        M_REFILL
    } miss_state_e;

endpackage

// File: dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array #(
    parameter int NUM_SETS = 256
) (
    input  logic                        clk,
    input  logic                        rd_en,
    input  dcache_geom_pkg::index_t     rd_index,
    input  logic                        st_en,
    input  dcache_geom_pkg::way_t       st_way,
    input  dcache_geom_pkg::index_t     st_index,
    input  dcache_geom_pkg::line_strb_t st_byte_en,
    input  dcache_geom_pkg::line_t      st_line,
    input  logic                        fill_en,
    input  dcache_geom_pkg::way_t       fill_way,
    input  dcache_geom_pkg::index_t     fill_index,
    input  dcache_geom_pkg::line_t      fill_line,
    output dcache_geom_pkg::line_t      line_way0,
    output dcache_geom_pkg::line_t      line_way1
);

    import dcache_geom_pkg::*;

    line_t line_mem [2][NUM_SETS];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            line_mem[fill_way][fill_index] <= fill_line;
        end else if (st_en) begin
            // Byte-enabled store from the write buffer
            for (int b = 0; b < LINE_W / 8; b++) begin
                if (st_byte_en[b]) begin
                    line_mem[st_way][st_index][b*8 +: 8] <= st_line[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            line_way0 <= line_mem[0][rd_index];
            line_way1 <= line_mem[1][rd_index];
        end
    end

    assert property (@(posedge clk) !(st_en && fill_en));

endmodule

// File: dcache_geom_pkg.sv
package dcache_geom_pkg;

    // Address split: tag | index | byte offset
    parameter int TAG_W          = 20;
    parameter int INDEX_W        = 8;
    parameter int OFFSET_W       = 4;

    parameter int WORD_W         = 32;
    parameter int WORDS_PER_LINE = 4;
    parameter int LINE_W         = WORD_W * WORDS_PER_LINE;

    typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] addr_t;
    typedef logic [TAG_W-1:0]                  tag_t;
    typedef logic [INDEX_W-1:0]                index_t;
    typedef logic [OFFSET_W-1:0]               offset_t;

    typedef logic [WORD_W-1:0]                 word_t;
    typedef logic [WORD_W/8-1:0]               strb_t;
    typedef logic [LINE_W-1:0]                 line_t;
    typedef logic [LINE_W/8-1:0]               line_strb_t;

    // Two ways
    typedef logic [0:0]                        way_t;

endpackage

// File: dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  logic                        op,
    input  dcache_geom_pkg::tag_t       tag,
    input  dcache_geom_pkg::index_t     index,
    input  dcache_geom_pkg::offset_t    offset,
    input  dcache_geom_pkg::strb_t      wstrb,
    input  dcache_geom_pkg::word_t      wdata,
    output logic                        addr_ok,
    output logic                        data_ok,
    output dcache_geom_pkg::word_t      rdata,
    output logic                        rd_en,
    output dcache_geom_pkg::index_t     rd_index,
    output logic                        st_en,
    output dcache_geom_pkg::way_t       st_way,
    output dcache_geom_pkg::index_t     st_index,
    output dcache_geom_pkg::line_strb_t st_byte_en,
    output dcache_geom_pkg::line_t      st_line,
    output logic                        miss_start,
    output logic                        req_op,
    output dcache_geom_pkg::tag_t       req_tag,
    output dcache_geom_pkg::index_t     req_index,
    output dcache_geom_pkg::offset_t    req_offset,
    output dcache_geom_pkg::strb_t      req_wstrb,
    output dcache_geom_pkg::word_t      req_wdata,
    input  dcache_geom_pkg::tag_t       tag_way0,
    input  dcache_geom_pkg::tag_t       tag_way1,
    input  logic [1:0]                  valid_bits,
    input  dcache_geom_pkg::line_t      line_way0,
    input  dcache_geom_pkg::line_t      line_way1,
    input  logic                        refill_done,
    input  dcache_geom_pkg::word_t      refill_word
);

    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;

    lookup_state_e state;
    lookup_state_e state_next;
    logic          hit0;
    logic          hit1;
    logic          lookup_hit;
    logic          accept;
    line_t         hit_line;

    logic          wb_valid;
    way_t          wb_way;
    index_t        wb_index;
    logic [1:0]    wb_word;
    strb_t         wb_wstrb;
    word_t         wb_wdata;

    assign hit0       = valid_bits[0] && (tag_way0 == req_tag);
    assign hit1       = valid_bits[1] && (tag_way1 == req_tag);
    assign lookup_hit = (state == L_LOOKUP) && (hit0 || hit1);
    assign miss_start = (state == L_LOOKUP) && !(hit0 || hit1);

    // Store hit holds off new requests until its write lands
    assign addr_ok = valid && !wb_valid &&
                     ((state == L_IDLE) || (lookup_hit && !req_op));
    assign accept   = valid && addr_ok;
    assign rd_en    = accept;
    assign rd_index = index;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op     <= op;
            req_tag    <= tag;
            req_index  <= index;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    assign hit_line = hit1 ? line_way1 : line_way0;
    assign data_ok  = lookup_hit || refill_done;
    assign rdata    = refill_done ? refill_word : hit_line[req_offset[3:2]*WORD_W +: WORD_W];

    always_comb begin
        state_next = state;
        case (state)
            L_IDLE: begin
                if (accept) begin
                    state_next = L_LOOKUP;
                end
            end
            L_LOOKUP: begin
                if (miss_start) begin
                    state_next = L_WAIT;
                end else if (!accept) begin
                    state_next = L_IDLE;
                end
            end
            L_WAIT: begin
                if (refill_done) begin
                    state_next = L_IDLE;
                end
            end
            default: state_next = L_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= L_IDLE;
            wb_valid <= 1'b0;
        end else begin
            state    <= state_next;
            wb_valid <= lookup_hit && req_op;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit && req_op) begin
            wb_way   <= hit1;
            wb_index <= req_index;
            wb_word  <= req_offset[3:2];
            wb_wstrb <= req_wstrb;
            wb_wdata <= req_wdata;
        end
    end

    assign st_en      = wb_valid;
    assign st_way     = wb_way;
    assign st_index   = wb_index;
    assign st_byte_en = line_strb_t'(wb_wstrb) << {wb_word, 2'b00};
    assign st_line    = {WORDS_PER_LINE{wb_wdata}};

    // Refill must only finish a miss that this stage is waiting on
    assert property (@(posedge clk) disable iff (!resetn) (state == L_IDLE) |-> !data_ok);

endmodule

// File: dcache_miss_ctrl.sv
`timescale 1ns/1ps

module dcache_miss_ctrl #(
    parameter logic [7:0] REPL_SEED = 8'h5a
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     miss_start,
    input  logic                     req_op,
    input  dcache_geom_pkg::tag_t    req_tag,
    input  dcache_geom_pkg::index_t  req_index,
    input  dcache_geom_pkg::offset_t req_offset,
    input  dcache_geom_pkg::strb_t   req_wstrb,
    input  dcache_geom_pkg::word_t   req_wdata,
    input  dcache_geom_pkg::tag_t    tag_way0,
    input  dcache_geom_pkg::tag_t    tag_way1,
    input  logic [1:0]               valid_bits,
    input  logic [1:0]               dirty_bits,
    input  dcache_geom_pkg::line_t   line_way0,
    input  dcache_geom_pkg::line_t   line_way1,
    output logic                     rd_req,
    output dcache_geom_pkg::addr_t   rd_addr,
    input  logic                     rd_rdy,
    input  logic                     ret_valid,
    input  dcache_geom_pkg::line_t   ret_data,
    output logic                     wr_req,
    output dcache_geom_pkg::addr_t   wr_addr,
    output dcache_geom_pkg::line_t   wr_data,
    input  logic                     wr_rdy,
    output logic                     fill_en,
    output dcache_geom_pkg::way_t    fill_way,
    output dcache_geom_pkg::index_t  fill_index,
    output dcache_geom_pkg::tag_t    fill_tag,
    output logic                     fill_dirty,
    output dcache_geom_pkg::line_t   fill_line,
    output logic                     refill_done,
    output dcache_geom_pkg::word_t   refill_word
);

    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;

    miss_state_e state;
    miss_state_e state_next;
    logic [7:0]  lfsr;
    logic        feedback;
    way_t        vic_sel;
    logic        vic_wb_sel;

    way_t        vic_way;
    tag_t        vic_tag;
    line_t       vic_line;

    line_strb_t  store_mask;
    line_t       store_line;
    line_t       merged_line;

    // Zero state folds back in, so any seed works
    assign feedback = lfsr[7] ^ ~|lfsr[6:0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= REPL_SEED;
        end else begin
            lfsr <= {lfsr[6:4], lfsr[3:1] ^ {3{feedback}}, lfsr[0], feedback};
        end
    end

    assign vic_sel    = lfsr[0];
    assign vic_wb_sel = valid_bits[vic_sel] && dirty_bits[vic_sel];

    always_ff @(posedge clk) begin
        if (miss_start) begin
            vic_way  <= vic_sel;
            vic_tag  <= vic_sel ? tag_way1 : tag_way0;
            vic_line <= vic_sel ? line_way1 : line_way0;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            M_IDLE: begin
                if (miss_start) begin
                    state_next = vic_wb_sel ? M_WRITEBACK : M_READ;
                end
            end
            M_WRITEBACK: begin
                if (wr_rdy) begin
                    state_next = M_READ;
                end
            end
            M_READ: begin
                if (rd_rdy) begin
                    state_next = M_REFILL;
                end
            end
            M_REFILL: begin
                if (ret_valid) begin
                    state_next = M_IDLE;
                end
            end
            default: state_next = M_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= M_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign wr_req  = (state == M_WRITEBACK);
    assign wr_addr = {vic_tag, req_index, {OFFSET_W{1'b0}}};
    assign wr_data = vic_line;
    assign rd_req  = (state == M_READ);
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

    // Write-allocate merge of the store bytes
    always_comb begin
        store_mask  = req_op ? (line_strb_t'(req_wstrb) << {req_offset[3:2], 2'b00}) : '0;
        store_line  = {WORDS_PER_LINE{req_wdata}};
        merged_line = ret_data;
        for (int b = 0; b < LINE_W / 8; b++) begin
            if (store_mask[b]) begin
                merged_line[b*8 +: 8] = store_line[b*8 +: 8];
            end
        end
    end

    assign fill_en     = (state == M_REFILL) && ret_valid;
    assign fill_way    = vic_way;
    assign fill_index  = req_index;
    assign fill_tag    = req_tag;
    assign fill_dirty  = req_op;
    assign fill_line   = merged_line;
    assign refill_done = fill_en;
    assign refill_word = ret_data[req_offset[3:2]*WORD_W +: WORD_W];

    assert property (@(posedge clk) disable iff (!resetn) !(rd_req && wr_req));

endmodule

// File: dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array #(
    parameter int NUM_SETS = 256
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    rd_en,
    input  dcache_geom_pkg::index_t rd_index,
    input  logic                    st_en,
    input  dcache_geom_pkg::way_t   st_way,
    input  dcache_geom_pkg::index_t st_index,
    input  logic                    fill_en,
    input  dcache_geom_pkg::way_t   fill_way,
    input  dcache_geom_pkg::index_t fill_index,
    input  dcache_geom_pkg::tag_t   fill_tag,
    input  logic                    fill_dirty,
    output dcache_geom_pkg::tag_t   tag_way0,
    output dcache_geom_pkg::tag_t   tag_way1,
    output logic [1:0]              valid_bits,
    output logic [1:0]              dirty_bits
);

    import dcache_geom_pkg::*;

    tag_t                tag_mem [2][NUM_SETS];
    logic [NUM_SETS-1:0] valid_mem [2];
    logic [NUM_SETS-1:0] dirty_mem [2];
    index_t              rd_index_q;

    // Tags only change on refill
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][fill_index] <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_mem[0] <= '0;
            valid_mem[1] <= '0;
            dirty_mem[0] <= '0;
            dirty_mem[1] <= '0;
        end else if (fill_en) begin
            valid_mem[fill_way][fill_index] <= 1'b1;
            dirty_mem[fill_way][fill_index] <= fill_dirty;
        end else if (st_en) begin
            dirty_mem[st_way][st_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            tag_way0   <= tag_mem[0][rd_index];
            tag_way1   <= tag_mem[1][rd_index];
            valid_bits <= {valid_mem[1][rd_index], valid_mem[0][rd_index]};
            rd_index_q <= rd_index;
        end
    end

    // Dirty view tracks stores landing after the read
    assign dirty_bits = {dirty_mem[1][rd_index_q], dirty_mem[0][rd_index_q]};

    // Write buffer and refill never collide
    assert property (@(posedge clk) disable iff (!resetn) !(st_en && fill_en));

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int         NUM_SETS  = 256,
    parameter logic [7:0] REPL_SEED = 8'h5a
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     valid,
    input  logic                     op,
    input  dcache_geom_pkg::tag_t    tag,
    input  dcache_geom_pkg::index_t  index,
    input  dcache_geom_pkg::offset_t offset,
    input  dcache_geom_pkg::strb_t   wstrb,
    input  dcache_geom_pkg::word_t   wdata,
    output logic                     addr_ok,
    output logic                     data_ok,
    output dcache_geom_pkg::word_t   rdata,
    output logic                     rd_req,
    output dcache_geom_pkg::addr_t   rd_addr,
    input  logic                     rd_rdy,
    input  logic                     ret_valid,
    input  dcache_geom_pkg::line_t   ret_data,
    output logic                     wr_req,
    output dcache_geom_pkg::addr_t   wr_addr,
    output dcache_geom_pkg::line_t   wr_data,
    input  logic                     wr_rdy
);

    import dcache_geom_pkg::*;

    logic       rd_en;
    index_t     rd_index;
    logic       st_en;
    way_t       st_way;
    index_t     st_index;
    line_strb_t st_byte_en;
    line_t      st_line;

    logic       miss_start;
    logic       req_op;
    tag_t       req_tag;
    index_t     req_index;
    offset_t    req_offset;
    strb_t      req_wstrb;
    word_t      req_wdata;
    logic       refill_done;
    word_t      refill_word;

    logic       fill_en;
    way_t       fill_way;
    index_t     fill_index;
    tag_t       fill_tag;
    logic       fill_dirty;
    line_t      fill_line;

    tag_t       tag_way0;
    tag_t       tag_way1;
    logic [1:0] valid_bits;
    logic [1:0] dirty_bits;
    line_t      line_way0;
    line_t      line_way1;

    dcache_lookup u_lookup (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .op          (op),
        .tag         (tag),
        .index       (index),
        .offset      (offset),
        .wstrb       (wstrb),
        .wdata       (wdata),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .st_en       (st_en),
        .st_way      (st_way),
        .st_index    (st_index),
        .st_byte_en  (st_byte_en),
        .st_line     (st_line),
        .miss_start  (miss_start),
        .req_op      (req_op),
        .req_tag     (req_tag),
        .req_index   (req_index),
        .req_offset  (req_offset),
        .req_wstrb   (req_wstrb),
        .req_wdata   (req_wdata),
        .tag_way0    (tag_way0),
        .tag_way1    (tag_way1),
        .valid_bits  (valid_bits),
        .line_way0   (line_way0),
        .line_way1   (line_way1),
        .refill_done (refill_done),
        .refill_word (refill_word)
    );

    dcache_miss_ctrl #(
        .REPL_SEED (REPL_SEED)
    ) u_miss_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .miss_start  (miss_start),
        .req_op      (req_op),
        .req_tag     (req_tag),
        .req_index   (req_index),
        .req_offset  (req_offset),
        .req_wstrb   (req_wstrb),
        .req_wdata   (req_wdata),
        .tag_way0    (tag_way0),
        .tag_way1    (tag_way1),
        .valid_bits  (valid_bits),
        .dirty_bits  (dirty_bits),
        .line_way0   (line_way0),
        .line_way1   (line_way1),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_rdy      (wr_rdy),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_index  (fill_index),
        .fill_tag    (fill_tag),
        .fill_dirty  (fill_dirty),
        .fill_line   (fill_line),
        .refill_done (refill_done),
        .refill_word (refill_word)
    );

    dcache_tag_array #(
        .NUM_SETS (NUM_SETS)
    ) u_tag_array (
        .clk        (clk),
        .resetn     (resetn),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .st_en      (st_en),
        .st_way     (st_way),
        .st_index   (st_index),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .fill_dirty (fill_dirty),
        .tag_way0   (tag_way0),
        .tag_way1   (tag_way1),
        .valid_bits (valid_bits),
        .dirty_bits (dirty_bits)
    );

    dcache_data_array #(
        .NUM_SETS (NUM_SETS)
    ) u_data_array (
        .clk        (clk),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .st_en      (st_en),
        .st_way     (st_way),
        .st_index   (st_index),
        .st_byte_en (st_byte_en),
        .st_line    (st_line),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_index (fill_index),
        .fill_line  (fill_line),
        .line_way0  (line_way0),
        .line_way1  (line_way1)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f tb.f \
    -o tb_dcache_sim \
    && ./obj_dir/tb_dcache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
test -s sim.log || { echo "No simulation log produced"; exit 1; }
grep -q "Checks failed" sim.log && exit 1 || exit 0

// File: tb.f
dcache_geom_pkg.sv
dcache_ctrl_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_lookup.sv
dcache_miss_ctrl.sv
dcache_top.sv
tb_dcache.sv

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    import dcache_geom_pkg::*;

    localparam int N_DIRECTED = 14;
    localparam int N_RANDOM   = 400;
    localparam int MAX_CYCLES = 200 * (N_DIRECTED + N_RANDOM);

    logic        clk;
    logic        resetn;
    logic        valid;
    logic        op;
    tag_t        tag;
    index_t      index;
    offset_t     offset;
    strb_t       wstrb;
    word_t       wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    addr_t       rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    line_t       ret_data;
    logic        wr_req;
    addr_t       wr_addr;
    line_t       wr_data;
    logic        wr_rdy;

    // CPU view of memory, and what the bus has actually written
    line_t       ref_mem [addr_t];
    line_t       mem_img [addr_t];

    logic        pend_op [$];
    word_t       pend_exp [$];
    time         pend_time [$];
    int          issue_cnt;
    int          done_cnt;
    int          wb_cnt;
    int          cycles;
    time         last_lat;
    addr_t       cur_line;
    logic        first_req;

    dcache_top UUT (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic line_t fill_pattern(input addr_t la);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*WORD_W +: WORD_W] = fill_word(la + addr_t'(w * 4));
        end
        return l;
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return {a[31:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    // Expected line as the CPU has written it so far
    function automatic line_t ref_line(input addr_t a);
        if (ref_mem.exists(line_of(a))) begin
            return ref_mem[line_of(a)];
        end
        return fill_pattern(line_of(a));
    endfunction

    function automatic line_t mem_line(input addr_t a);
        if (mem_img.exists(line_of(a))) begin
            return mem_img[line_of(a)];
        end
        return fill_pattern(line_of(a));
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic ref_store(input addr_t a, input strb_t s, input word_t d);
        line_t l;
        int    base;
        l    = ref_line(a);
        base = int'(a[3:2]) * WORD_W;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                l[base + b*8 +: 8] = d[b*8 +: 8];
            end
        end
        ref_mem[line_of(a)] = l;
    endtask

    // Starts right after a falling edge, returns on a falling edge once data_ok was seen
    task automatic cpu_access(input logic st, input addr_t a, input strb_t s, input word_t d);
        line_t l;
        logic  accepted;
        valid    <= 1'b1;
        op       <= st;
        tag      <= a[31:12];
        index    <= a[11:4];
        offset   <= a[3:0];
        wstrb    <= s;
        wdata    <= d;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            if (first_req) begin
                check_value("addr_ok", addr_ok, 1'b1);
                first_req = 1'b0;
            end
            accepted = addr_ok;
        end
        l = ref_line(a);
        pend_op.push_back(st);
        pend_exp.push_back(l[int'(a[3:2])*WORD_W +: WORD_W]);
        pend_time.push_back($time);
        cur_line = line_of(a);
        if (st) begin
            ref_store(a, s, d);
        end
        issue_cnt++;
        @(negedge clk);
        valid <= 1'b0;
        while (done_cnt != issue_cnt) begin
            @(negedge clk);
        end
    endtask

    // Response checker
    always @(posedge clk) begin
        logic  e_op;
        word_t e_word;
        time   e_time;
        if (resetn && data_ok) begin
            if (pend_op.size() == 0) begin
                $display("data_ok pulsed at %0t with no request outstanding", $time);
                abort_run();
            end else begin
                e_op   = pend_op.pop_front();
                e_word = pend_exp.pop_front();
                e_time = pend_time.pop_front();
                if (!e_op) begin
                    check_value("rdata", rdata, e_word);
                end
                last_lat = ($time - e_time) / 100;
                done_cnt++;
            end
        end
    end

    // Memory write side
    always @(posedge clk) begin
        if (resetn && wr_req && wr_rdy) begin
            check_value("wr_addr", wr_addr, line_of(wr_addr));
            check_value("wr_data", wr_data, ref_line(wr_addr));
            mem_img[wr_addr] = wr_data;
            wb_cnt++;
        end
    end

    // Memory read side, line returns 1 to 4 cycles after the handshake
    always @(posedge clk) begin
        int    delay;
        line_t data;
        if (resetn && rd_req && rd_rdy) begin
            check_value("rd_addr", rd_addr, cur_line);
            data  = mem_line(rd_addr);
            delay = 1 + int'($urandom % 4);
            repeat (delay - 1) @(posedge clk);
            @(negedge clk);
            ret_valid <= 1'b1;
            ret_data  <= data;
            @(negedge clk);
            ret_valid <= 1'b0;
        end
    end

    always @(negedge clk) begin
        rd_rdy <= ($urandom % 3) != 0;
        wr_rdy <= ($urandom % 3) != 0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    initial begin
        addr_t a;
        tag_t  tg;
        void'($urandom(32'h4576_82a4));
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        issue_cnt = 0;
        done_cnt  = 0;
        wb_cnt    = 0;
        cycles    = 0;
        last_lat  = 0;
        first_req = 1'b1;
        cur_line  = '0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        check_value("data_ok", data_ok, 1'b0);
        check_value("rd_req", rd_req, 1'b0);
        check_value("wr_req", wr_req, 1'b0);
        @(negedge clk);

        // Load miss, then hit on the same line
        cpu_access(1'b0, 32'h0001_2344, 4'h0, 32'h0);
        cpu_access(1'b0, 32'h0001_2344, 4'h0, 32'h0);
        check_value("hit latency", last_lat, 1);

        // Partial store hit
        cpu_access(1'b1, 32'h0001_2348, 4'b0101, 32'hdead_beef);
        check_value("hit latency", last_lat, 1);
        cpu_access(1'b0, 32'h0001_2348, 4'h0, 32'h0);

        // Partial store miss, merged into the refill
        cpu_access(1'b1, 32'h0003_4564, 4'b1010, 32'h1234_5678);
        cpu_access(1'b0, 32'h0003_4564, 4'h0, 32'h0);

        // Four tags on one set force dirty evictions
        cpu_access(1'b1, 32'h0010_0200, 4'hf, 32'h1111_0001);
        cpu_access(1'b1, 32'h0020_0204, 4'hf, 32'h2222_0002);
        cpu_access(1'b1, 32'h0030_0208, 4'hf, 32'h3333_0003);
        cpu_access(1'b1, 32'h0040_020c, 4'hf, 32'h4444_0004);
        cpu_access(1'b0, 32'h0010_0200, 4'h0, 32'h0);
        cpu_access(1'b0, 32'h0020_0204, 4'h0, 32'h0);
        cpu_access(1'b0, 32'h0030_0208, 4'h0, 32'h0);
        cpu_access(1'b0, 32'h0040_020c, 4'h0, 32'h0);
        check_value("write-back seen", wb_cnt >= 2, 1'b1);

        // Random mix over three sets and five tags
        for (int i = 0; i < N_RANDOM; i++) begin
            tg = tag_t'(20'h00050 + ($urandom % 5));
            a  = {tg, index_t'($urandom % 3), 2'($urandom % 4), 2'b00};
            cpu_access(1'($urandom % 2), a, 4'($urandom), $urandom);
        end

        repeat (3) @(negedge clk);
        if (pend_op.size() != 0 || done_cnt != issue_cnt) begin
            $display("Requests were still outstanding at the end of the run");
            abort_run();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule
